/* src/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // cache geometry fixed by the 16-bit address split
    localparam int WORD_WIDTH     = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_WIDTH     = WORD_WIDTH * WORDS_PER_LINE;
    localparam int OFFSET_BITS    = $clog2(WORDS_PER_LINE);
    localparam int INDEX_BITS     = 1;
    localparam int NUM_SETS       = 2 ** INDEX_BITS;
    localparam int TAG_BITS       = WORD_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int NUM_WAYS       = 2;

    typedef logic [WORD_WIDTH-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [LINE_WIDTH-1:0] line_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } cpu_addr_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic                recent;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef tag_entry_t [NUM_WAYS-1:0] way_tags_t;
    typedef line_t [NUM_WAYS-1:0] way_lines_t;

    typedef struct packed {
        logic      valid;
        logic      read;
        logic      write;
        cpu_addr_t address;
        word_t     write_data;
    } cpu_req_t;

    typedef struct packed {
        logic  input_ready;
        logic  ack_output;
        word_t read_data;
    } cpu_rsp_t;

    // line-wide memory port with a line aligned address
    typedef struct packed {
        logic      read;
        logic      write;
        cpu_addr_t address;
        line_t     write_data;
    } mem_req_t;

    typedef struct packed {
        logic  input_ready;
        logic  ack_output;
        line_t read_data;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        st_check,
        st_allocate,
        st_write_back
    } cache_state_t;

    function automatic word_t select_word(line_t cache_line, logic [OFFSET_BITS-1:0] offset);
        return cache_line[offset*WORD_WIDTH +: WORD_WIDTH];
    endfunction

    function automatic line_t merge_word(line_t cache_line, logic [OFFSET_BITS-1:0] offset,
                                         word_t data);
        line_t merged;
        merged = cache_line;
        merged[offset*WORD_WIDTH +: WORD_WIDTH] = data;
        return merged;
    endfunction

endpackage

`default_nettype wire

/* src/cache_tag_array.sv */
`default_nettype none

module cache_tag_array (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic [cache_pkg::INDEX_BITS-1:0] index,
    input  logic                             tag_we,
    input  cache_pkg::way_tags_t             tag_write,
    output cache_pkg::way_tags_t             tag_read
);

    import cache_pkg::*;

    // one entry per way in every set
    way_tags_t entries [NUM_SETS];

    // combinational read of the presented set
    assign tag_read = entries[index];

    // both ways of a set are written together
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                entries[s] <= '0;
            end
        end else if (tag_we) begin
            entries[index] <= tag_write;
        end
    end

endmodule

`default_nettype wire

/* src/cache_data_array.sv */
`default_nettype none

module cache_data_array (
    input  logic                             clk,
    input  logic [cache_pkg::INDEX_BITS-1:0] index,
    input  logic                             line_we,
    input  cache_pkg::way_lines_t            line_write,
    output cache_pkg::way_lines_t            line_read
);

    import cache_pkg::*;

    way_lines_t lines [NUM_SETS];

    assign line_read = lines[index];

    // both ways of the indexed set are written together
    always_ff @(posedge clk) begin
        if (line_we) begin
            lines[index] <= line_write;
        end
    end

endmodule

`default_nettype wire

/* src/cache_controller.sv */
`default_nettype none

module cache_controller (
    input  logic                             clk,
    input  logic                             reset_n,
    input  cache_pkg::cpu_req_t              cpu_req,
    output cache_pkg::cpu_rsp_t              cpu_rsp,
    output cache_pkg::mem_req_t              mem_req,
    input  cache_pkg::mem_rsp_t              mem_rsp,
    output logic [cache_pkg::INDEX_BITS-1:0] index,
    output logic                             tag_we,
    output cache_pkg::way_tags_t             tag_write,
    input  cache_pkg::way_tags_t             tag_read,
    output logic                             line_we,
    output cache_pkg::way_lines_t            line_write,
    input  cache_pkg::way_lines_t            line_read
);

    import cache_pkg::*;

    cache_state_t        state;
    cache_state_t        next_state;
    cpu_addr_t           addr;
    logic [NUM_WAYS-1:0] hit_way;
    logic                hit;
    logic                hit_sel;
    logic                new_victim;
    logic                victim_dirty;
    logic                victim_way;
    logic                access;

    assign addr   = cpu_req.address;
    assign index  = addr.index;
    assign access = cpu_req.valid && (cpu_req.read || cpu_req.write);

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way[w] = tag_read[w].valid && (tag_read[w].tag == addr.tag);
        end
    end

    assign hit     = |hit_way;
    assign hit_sel = hit_way[1];

    // way 0 is evicted unless it was used last
    assign new_victim   = tag_read[0].recent;
    assign victim_dirty = tag_read[new_victim].valid && tag_read[new_victim].dirty;

    always_comb begin
        next_state = state;
        tag_we     = 1'b0;
        line_we    = 1'b0;
        // unchanged entries are written back as they were read
        tag_write  = tag_read;
        line_write = line_read;
        mem_req    = '0;
        cpu_rsp    = '0;
        cpu_rsp.read_data = select_word(line_read[hit_sel], addr.offset);

        case (state)
            st_check: begin
                if (access) begin
                    if (hit) begin
                        tag_we = 1'b1;
                        for (int w = 0; w < NUM_WAYS; w++) begin
                            tag_write[w].recent = (1'(w) == hit_sel);
                        end
                        if (cpu_req.write) begin
                            line_we = 1'b1;
                            line_write[hit_sel] = merge_word(line_read[hit_sel], addr.offset,
                                                             cpu_req.write_data);
                            tag_write[hit_sel].dirty = 1'b1;
                            cpu_rsp.ack_output = 1'b1;
                        end else begin
                            cpu_rsp.input_ready = 1'b1;
                        end
                    end else if (victim_dirty) begin
                        next_state = st_write_back;
                    end else begin
                        next_state = st_allocate;
                    end
                end
            end

            st_write_back: begin
                // victim goes back to its own line address with offset zero
                mem_req.write         = 1'b1;
                mem_req.address.tag   = tag_read[victim_way].tag;
                mem_req.address.index = addr.index;
                mem_req.write_data    = line_read[victim_way];
                if (mem_rsp.ack_output) begin
                    next_state = st_allocate;
                end
            end

            st_allocate: begin
                mem_req.read          = 1'b1;
                mem_req.address.tag   = addr.tag;
                mem_req.address.index = addr.index;
                if (mem_rsp.input_ready) begin
                    tag_we  = 1'b1;
                    line_we = 1'b1;
                    for (int w = 0; w < NUM_WAYS; w++) begin
                        tag_write[w].recent = (1'(w) == victim_way);
                    end
                    tag_write[victim_way].valid = 1'b1;
                    tag_write[victim_way].dirty = cpu_req.write;
                    tag_write[victim_way].tag   = addr.tag;

                    // a write miss lands its word in the refilled line
                    if (cpu_req.write) begin
                        line_write[victim_way] = merge_word(mem_rsp.read_data, addr.offset,
                                                            cpu_req.write_data);
                    end else begin
                        line_write[victim_way] = mem_rsp.read_data;
                    end

                    cpu_rsp.input_ready = !cpu_req.write;
                    cpu_rsp.ack_output  = cpu_req.write;
                    cpu_rsp.read_data   = select_word(mem_rsp.read_data, addr.offset);
                    next_state = st_check;
                end
            end

            default: begin
                next_state = st_check;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= st_check;
            victim_way <= 1'b0;
        end else begin
            state <= next_state;
            // victim is fixed when the miss leaves st_check
            if (state == st_check) begin
                victim_way <= new_victim;
            end
        end
    end

endmodule

`default_nettype wire

/* src/data_cache.sv */
`default_nettype none

module data_cache (
    input  logic                clk,
    input  logic                reset_n,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    import cache_pkg::*;

    logic [INDEX_BITS-1:0] index;
    logic                  tag_we;
    way_tags_t             tag_write;
    way_tags_t             tag_read;
    logic                  line_we;
    way_lines_t            line_write;
    way_lines_t            line_read;

    cache_controller controller (
        .clk        (clk),
        .reset_n    (reset_n),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .index      (index),
        .tag_we     (tag_we),
        .tag_write  (tag_write),
        .tag_read   (tag_read),
        .line_we    (line_we),
        .line_write (line_write),
        .line_read  (line_read)
    );

    cache_tag_array tag_array (
        .clk       (clk),
        .reset_n   (reset_n),
        .index     (index),
        .tag_we    (tag_we),
        .tag_write (tag_write),
        .tag_read  (tag_read)
    );

    cache_data_array data_array (
        .clk        (clk),
        .index      (index),
        .line_we    (line_we),
        .line_write (line_write),
        .line_read  (line_read)
    );

endmodule

`default_nettype wire

/* sim/tb_memory.sv */
`default_nettype none

module tb_memory (
    input  logic                clk,
    input  logic                reset_n,
    input  cache_pkg::mem_req_t mem_req,
    output cache_pkg::mem_rsp_t mem_rsp
);

    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;

    localparam int MEM_WORDS = 65536;

    word_t       storage [MEM_WORDS];
    logic [31:0] lfsr;
    mem_req_t    pending;
    int          wait_cycles;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] value);
        logic feedback;
        feedback = value[31] ^ value[21] ^ value[1] ^ value[0];
        return {value[30:0], feedback};
    endfunction

    // one step for every latency bit, giving 1 to 8 cycles
    task automatic draw_latency(output int cycles);
        logic [2:0] bits;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_step(lfsr);
            bits[b] = lfsr[0];
        end
        cycles = int'(bits) + 1;
    endtask

    task automatic serve_request(input mem_req_t req);
        logic [15:0] base;
        base = req.address;
        base[OFFSET_BITS-1:0] = '0;
        if (req.write) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                storage[base + 16'(w)] = req.write_data[w*WORD_WIDTH +: WORD_WIDTH];
            end
            mem_rsp.ack_output = 1'b1;
        end else begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem_rsp.read_data[w*WORD_WIDTH +: WORD_WIDTH] = storage[base + 16'(w)];
            end
            mem_rsp.input_ready = 1'b1;
        end
    endtask

    // every word starts as its own address scrambled
    initial begin
        for (int a = 0; a < MEM_WORDS; a++) begin
            storage[a] = 16'(a) ^ 16'hA5A5;
        end
    end

    initial begin
        lfsr = 32'h0550_d3d1;
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (reset_n && (mem_req.read || mem_req.write)) begin
                pending = mem_req;
                draw_latency(wait_cycles);
                repeat (wait_cycles) @(posedge clk);
                #1;
                serve_request(pending);
                // response is a single cycle pulse
                @(posedge clk);
                #1;
                mem_rsp = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_data_cache.sv */
`default_nettype none

module tb_data_cache;

    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;

    localparam int    RESET_CYCLES = 16;
    localparam int    MAX_WAIT     = 64;
    localparam string STIM_FILE    = "sim/cache_stimulus.txt";

    logic     clk;
    logic     reset_n;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    int       fd;
    int       status;
    int       line_no;
    string    text;

    data_cache UUT (
        .clk     (clk),
        .reset_n (reset_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    tb_memory memory (
        .clk     (clk),
        .reset_n (reset_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [15:0] expected, logic [15:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic drive_request(logic is_write, logic [15:0] address, word_t data);
        @(posedge clk);
        #1;
        cpu_req.valid      = 1'b1;
        cpu_req.read       = !is_write;
        cpu_req.write      = is_write;
        cpu_req.address    = address;
        cpu_req.write_data = data;
    endtask

    // sampled on the falling edge where cache and memory outputs are settled
    task automatic wait_response(input int line_idx, output int cycles, output logic saw_read,
                                 output logic saw_write, output cpu_rsp_t rsp);
        logic done;
        done      = 1'b0;
        cycles    = 0;
        saw_read  = 1'b0;
        saw_write = 1'b0;
        rsp       = '0;
        while (!done && cycles < MAX_WAIT) begin
            @(negedge clk);
            if (mem_req.read) begin
                saw_read = 1'b1;
            end
            if (mem_req.write) begin
                saw_write = 1'b1;
            end
            if (cpu_rsp.input_ready || cpu_rsp.ack_output) begin
                rsp  = cpu_rsp;
                done = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!done) begin
            $display("no response arrived for stimulus line %0d within %0d cycles",
                     line_idx, MAX_WAIT);
            abort_run();
        end
    endtask

    task automatic run_line(string line_text, int line_idx);
        byte         op;
        byte         outcome;
        logic [15:0] address;
        logic [15:0] data;
        int          fields;
        int          cycles;
        logic        saw_read;
        logic        saw_write;
        logic        seen_hit;
        cpu_rsp_t    rsp;
        string       name;
        fields = $sscanf(line_text, "%c %c %h %h", op, outcome, address, data);
        if (fields != 4) begin
            $display("stimulus line %0d could not be parsed", line_idx);
            abort_run();
        end else begin
            name = $sformatf("line %0d %c %h", line_idx, op, address);
            drive_request(op == "W", address, data);
            wait_response(line_idx, cycles, saw_read, saw_write, rsp);
            // a hit answers in the request cycle without touching memory
            seen_hit = (cycles == 0) && !saw_read && !saw_write;
            check_value({name, " hit"}, 16'(outcome == "H"), 16'(seen_hit));
            check_value({name, " refill"}, 16'(outcome != "H"), 16'(saw_read));
            check_value({name, " write-back"}, 16'(outcome == "D"), 16'(saw_write));
            check_value({name, " ack"}, 16'(op == "W"), 16'(rsp.ack_output));
            check_value({name, " ready"}, 16'(op != "W"), 16'(rsp.input_ready));
            if (op != "W") begin
                check_value({name, " data"}, data, rsp.read_data);
            end
        end
    endtask

    initial begin
        cpu_req = '0;
        reset_n = 1'b0;
        line_no = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                text = "";
                status = $fgets(text, fd);
                line_no++;
                // comment and blank lines carry no access
                if (status != 0 && text.len() > 0 && text.getc(0) != "#" &&
                    text.getc(0) != "\n") begin
                    run_line(text, line_no);
                end
            end
            $fclose(fd);
            @(posedge clk);
            #1;
            cpu_req = '0;
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
src/cache_pkg.sv
src/cache_tag_array.sv
src/cache_data_array.sv
src/cache_controller.sv
src/data_cache.sv
sim/tb_memory.sv
sim/tb_data_cache.sv

/* Makefile */
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_data_cache
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary -j $(JOBS)

SOURCES := $(wildcard src/*.sv sim/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN) sim/cache_stimulus.txt
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx 'test passed' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/cache_stimulus.txt */
# op (R read, W write), outcome (H hit, M miss, D miss with dirty write-back),
# word address in hex, then write data or expected read data in hex
R M 0010 a5b5
R H 0012 a5b7
W H 0011 1234
R H 0011 1234
R H 0013 a5b6
R M 0020 a585
R H 0010 a5b5
R M 0030 a595
R H 0011 1234
R M 0021 a584
R D 0040 a5e5
R M 0011 1234
R H 0010 a5b5
R H 0012 a5b7
W M 0105 beef
R H 0105 beef
R H 0106 a4a3
W M 010d 5a5a
R D 0114 a4b1
R D 0105 beef
R M 010d 5a5a
